// ==== boundaryMask.sv ====
`include "predecoder_params.svh"
`timescale 1ns/1ps
`default_nettype none

module boundaryMask (
  input  wire [`NUM_PARCELS-1:0]              endBits,
  input  wire                                 tailEnd,
  input  wire bundlePkg::offset_t             startOff,
  input  wire [`NUM_PARCELS-1:0]              jumpCls,
  output logic [`NUM_PARCELS-1:0]             valid,
  output logic [`NUM_PARCELS-1:0]             jumpFlag,
  output bundlePkg::magic_t [`NUM_PARCELS-1:0] magic,
  output logic                                overflow,
  output logic                                jumpOverflow,
  output logic                                hasJumps
);

  // Bit j holds end[j-1], so bit 0 is the implied end before parcel 0
  logic [`NUM_PARCELS+`MAX_LEN-1:0] endExt;
  logic [`NUM_PARCELS-1:0]          starts;
  logic [`CNT_W-1:0]                validCnt;
  logic [`CNT_W-1:0]                jumpCnt;

  assign endExt = {{(`MAX_LEN-2){1'b0}}, tailEnd, endBits, 1'b1};
  assign starts = endExt[`NUM_PARCELS-1:0];

  always_comb begin
    for (int k = 0; k < `NUM_PARCELS; k++) begin
      valid[k] = starts[k] && (bundlePkg::offset_t'(k) >= startOff);
      magic[k] = ~endExt[k+1 +: `MAX_LEN];  // End bits past the tail read as 0
    end
  end

  assign jumpFlag = jumpCls & valid;

  always_comb begin
    validCnt = '0;
    jumpCnt  = '0;
    for (int k = 0; k < `NUM_PARCELS; k++) begin
      validCnt = validCnt + {{(`CNT_W-1){1'b0}}, valid[k]};
      jumpCnt  = jumpCnt + {{(`CNT_W-1){1'b0}}, jumpFlag[k]};
    end
  end

  // Offset 15 points past the last parcel that can start an instruction
  assign overflow     = (validCnt > `CNT_W'(`INSTR_SLOTS)) ||
                        (startOff == bundlePkg::offset_t'(`NUM_PARCELS));
  assign jumpOverflow = jumpCnt > `CNT_W'(`JUMP_SLOTS);
  assign hasJumps     = jumpCnt != '0;

endmodule

`default_nettype wire

// ==== bundlePkg.sv ====
`include "predecoder_params.svh"
`default_nettype none

package bundlePkg;

  typedef logic [`PARCEL_W-1:0] parcel_t;

  // Four parcels, lowest parcel holds the opcode
  typedef parcel_t [`MAX_LEN-1:0] instrWord_t;

  // Inverted end bits of the own parcel and the three after it
  typedef logic [`MAX_LEN-1:0] magic_t;

  typedef logic [`OFF_W-1:0] offset_t;

  typedef struct packed {
    instrWord_t          word;
    magic_t              magic;
    offset_t             off;
    isaPkg::instrClass_t cls;
  } slotEntry_t;

  typedef struct packed {
    instrWord_t word;
    offset_t    off;
  } jumpEntry_t;

endpackage

`default_nettype wire

// ==== instrClassify.sv ====
`include "predecoder_params.svh"
`timescale 1ns/1ps
`default_nettype none

module instrClassify (
  input  wire bundlePkg::instrWord_t word,
  input  wire bundlePkg::magic_t     magic,
  output isaPkg::instrClass_t        cls
);

  isaPkg::opcode_t    opcode;
  isaPkg::subOpcode_t subOp;
  logic               longForm;

  logic aluGroup;
  logic isShift;
  logic isMem;
  logic isCondJump;
  logic isDirJump;
  logic isIndir;
  logic isSys;
  logic subAlu;
  logic subJump;

  assign opcode   = word[0][`OP_W-1:0];
  assign subOp    = word[0][`SUBOP_W-1:0];
  assign longForm = magic[0];  // Instruction continues past its own parcel

  // Long forms
  assign aluGroup = longForm && (opcode[7:5] == 3'b000 || opcode[7:3] == 5'b00100);

  assign isShift = longForm &&
                   opcode >= isaPkg::opShiftFirst &&
                   opcode <= isaPkg::opShiftLast;

  assign isMem      = longForm && opcode[7:6] == 2'b01;  // Bit 0 picks store
  assign isCondJump = longForm && opcode[7:4] == 4'b1010;

  assign isDirJump = longForm &&
                     (opcode == isaPkg::opLongJump || opcode == isaPkg::opUncondJump);

  assign isIndir = longForm && opcode == isaPkg::opIndirJump;
  assign isSys   = longForm && opcode == isaPkg::opSys;

  // One-parcel forms
  assign subAlu  = !longForm && subOp <= isaPkg::subAluLast;

  assign subJump = !longForm &&
                   subOp >= isaPkg::subJumpFirst &&
                   subOp <= isaPkg::subJumpLast;

  assign cls[isaPkg::clsIndir] = isIndir;
  assign cls[isaPkg::clsJump]  = isCondJump | isDirJump | isIndir | subJump;

  // Conditional jumps also set flags, so they count as ALU too
  assign cls[isaPkg::clsAlu]   = (aluGroup & ~opcode[2]) | isCondJump | subAlu;

  assign cls[isaPkg::clsShift] = isShift;
  assign cls[isaPkg::clsMul]   = aluGroup & opcode[2];
  assign cls[isaPkg::clsLoad]  = isMem & ~opcode[0];
  assign cls[isaPkg::clsStore] = isMem & opcode[0];
  assign cls[isaPkg::clsSys]   = isSys;

endmodule

`default_nettype wire

// ==== isaPkg.sv ====
`include "predecoder_params.svh"
`default_nettype none

package isaPkg;

  // One bit per reduced class
  typedef logic [`CLS_W-1:0] instrClass_t;

  localparam int clsIndir = 0;
  localparam int clsJump  = 1;
  localparam int clsAlu   = 2;
  localparam int clsShift = 3;
  localparam int clsMul   = 4;
  localparam int clsLoad  = 5;
  localparam int clsStore = 6;
  localparam int clsSys   = 7;

  // Main opcode of a long form, parcel 0 bits 7:0
  typedef logic [`OP_W-1:0] opcode_t;

  localparam opcode_t opShiftFirst = 8'd40;
  localparam opcode_t opShiftLast  = 8'd45;
  localparam opcode_t opLongJump   = 8'd180;
  localparam opcode_t opUncondJump = 8'd181;
  localparam opcode_t opIndirJump  = 8'd182;
  localparam opcode_t opSys        = 8'd255;

  // Sub-opcode of a one-parcel form, bits 5:0
  typedef logic [`SUBOP_W-1:0] subOpcode_t;

  localparam subOpcode_t subAluLast   = 6'd15;
  localparam subOpcode_t subJumpFirst = 6'd48;
  localparam subOpcode_t subJumpLast  = 6'd51;

endpackage

`default_nettype wire

// ==== predecoder.sv ====
`include "predecoder_params.svh"
`timescale 1ns/1ps
`default_nettype none

module predecoder (
  input  wire                                        clk,
  input  wire                                        reset,
  input  wire [`BUNDLE_W-1:0]                        bundle,
  input  wire [`TAIL_W-1:0]                          btail,
  input  wire bundlePkg::offset_t                    startOff,
  output bundlePkg::instrWord_t [`INSTR_SLOTS-1:0]   instr,
  output bundlePkg::magic_t [`INSTR_SLOTS-1:0]       magic,
  output bundlePkg::offset_t [`INSTR_SLOTS-1:0]      off,
  output isaPkg::instrClass_t [`INSTR_SLOTS-1:0]     cls,
  output logic [`INSTR_SLOTS-1:0]                    instrEn,
  output bundlePkg::instrWord_t [`JUMP_SLOTS-1:0]    jInstr,
  output bundlePkg::offset_t [`JUMP_SLOTS-1:0]       jOff,
  output logic [`JUMP_SLOTS-1:0]                     jumpEn,
  output logic                                       hasJumps,
  output logic                                       overflow,
  output logic                                       jumpOverflow
);

  // Parcels 0..14 from the bundle, 15 from the tail, then zero padding
  bundlePkg::parcel_t [`NUM_PARCELS+`MAX_LEN-1:0] parcels;

  bundlePkg::instrWord_t [`NUM_PARCELS-1:0]  word;
  bundlePkg::magic_t [`NUM_PARCELS-1:0]      pMagic;
  isaPkg::instrClass_t [`NUM_PARCELS-1:0]    pCls;
  logic [`NUM_PARCELS-1:0]                   jumpCls;
  logic [`NUM_PARCELS-1:0]                   valid;
  logic [`NUM_PARCELS-1:0]                   jumpFlag;
  bundlePkg::slotEntry_t [`NUM_PARCELS-1:0]  slotIn;
  bundlePkg::jumpEntry_t [`NUM_PARCELS-1:0]  jumpIn;

  bundlePkg::slotEntry_t [`INSTR_SLOTS-1:0]  slotOut;
  bundlePkg::jumpEntry_t [`JUMP_SLOTS-1:0]   jumpOut;
  logic [`INSTR_SLOTS-1:0]                   instrEnNext;
  logic [`JUMP_SLOTS-1:0]                    jumpEnNext;
  logic                                      hasJumpsNext;
  logic                                      overflowNext;
  logic                                      jumpOverflowNext;

  assign parcels = {{((`MAX_LEN-1)*`PARCEL_W){1'b0}},
                    btail[`PARCEL_W-1:0],
                    bundle[`NUM_PARCELS*`PARCEL_W-1:0]};

  boundaryMask boundary_i (
    .endBits      (bundle[`NUM_PARCELS*`PARCEL_W +: `NUM_PARCELS]),
    .tailEnd      (btail[`PARCEL_W]),
    .startOff     (startOff),
    .jumpCls      (jumpCls),
    .valid        (valid),
    .jumpFlag     (jumpFlag),
    .magic        (pMagic),
    .overflow     (overflowNext),
    .jumpOverflow (jumpOverflowNext),
    .hasJumps     (hasJumpsNext)
  );

  for (genvar k = 0; k < `NUM_PARCELS; k++) begin : gParcel
    assign word[k] = parcels[k +: `MAX_LEN];

    instrClassify classify_i (
      .word  (word[k]),
      .magic (pMagic[k]),
      .cls   (pCls[k])
    );

    assign jumpCls[k] = pCls[k][isaPkg::clsJump];
    assign slotIn[k]  = {word[k], pMagic[k], bundlePkg::offset_t'(k), pCls[k]};
    assign jumpIn[k]  = {word[k], bundlePkg::offset_t'(k)};
  end

  slotSelect #(.payload_t(bundlePkg::slotEntry_t), .NUM_SLOTS(`INSTR_SLOTS)) instrSel_i (
    .flag  (valid),
    .entry (slotIn),
    .slot  (slotOut),
    .en    (instrEnNext)
  );

  slotSelect #(.payload_t(bundlePkg::jumpEntry_t), .NUM_SLOTS(`JUMP_SLOTS)) jumpSel_i (
    .flag  (jumpFlag),
    .entry (jumpIn),
    .slot  (jumpOut),
    .en    (jumpEnNext)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      instr        <= '0;
      magic        <= '0;
      off          <= '0;
      cls          <= '0;
      instrEn      <= '0;
      jInstr       <= '0;
      jOff         <= '0;
      jumpEn       <= '0;
      hasJumps     <= 1'b0;
      overflow     <= 1'b0;
      jumpOverflow <= 1'b0;
    end else begin
      for (int i = 0; i < `INSTR_SLOTS; i++) begin
        instr[i] <= slotOut[i].word;
        magic[i] <= slotOut[i].magic;
        off[i]   <= slotOut[i].off;
        cls[i]   <= slotOut[i].cls;
      end
      for (int j = 0; j < `JUMP_SLOTS; j++) begin
        jInstr[j] <= jumpOut[j].word;
        jOff[j]   <= jumpOut[j].off;
      end
      instrEn      <= instrEnNext;
      jumpEn       <= jumpEnNext;
      hasJumps     <= hasJumpsNext;
      overflow     <= overflowNext;
      jumpOverflow <= jumpOverflowNext;
    end
  end

endmodule

`default_nettype wire

// ==== predecoder_params.svh ====
`ifndef PREDECODER_PARAMS_SVH
`define PREDECODER_PARAMS_SVH

// Parcel and bundle geometry
`define PARCEL_W     16
`define NUM_PARCELS  15
`define MAX_LEN      4

`define BUNDLE_W     256
`define TAIL_W       17

// Output slot counts
`define INSTR_SLOTS  12
`define JUMP_SLOTS   4

// Field widths
`define OFF_W        4
`define CNT_W        5   // Holds a count of 0 to 15
`define CLS_W        8
`define OP_W         8
`define SUBOP_W      6

`endif

// ==== predecoder_sva.sv ====
`include "predecoder_params.svh"
`timescale 1ns/1ps
`default_nettype none

module predecoder_sva (
  input wire                                        clk,
  input wire                                        reset,
  input wire bundlePkg::instrWord_t [`INSTR_SLOTS-1:0] instr,
  input wire bundlePkg::magic_t [`INSTR_SLOTS-1:0]     magic,
  input wire bundlePkg::offset_t [`INSTR_SLOTS-1:0]    off,
  input wire isaPkg::instrClass_t [`INSTR_SLOTS-1:0]   cls,
  input wire [`INSTR_SLOTS-1:0]                        instrEn,
  input wire bundlePkg::instrWord_t [`JUMP_SLOTS-1:0]  jInstr,
  input wire bundlePkg::offset_t [`JUMP_SLOTS-1:0]     jOff,
  input wire [`JUMP_SLOTS-1:0]                         jumpEn,
  input wire                                           hasJumps,
  input wire                                           overflow,
  input wire                                           jumpOverflow
);

  // Thermometer means no set bit above a clear one
  instrEnThermo: assert property (@(posedge clk) disable iff (reset)
    (instrEn & (instrEn + 1'b1)) == '0)
    else $error("instrEn is not a thermometer code");

  jumpEnThermo: assert property (@(posedge clk) disable iff (reset)
    (jumpEn & (jumpEn + 1'b1)) == '0)
    else $error("jumpEn is not a thermometer code");

  clearAfterReset: assert property (@(posedge clk) reset |=>
    (instr == '0 && magic == '0 && off == '0 && cls == '0 && instrEn == '0 &&
     jInstr == '0 && jOff == '0 && jumpEn == '0 && !hasJumps && !overflow && !jumpOverflow))
    else $error("Outputs not cleared after reset");

  hasJumpsMatch: assert property (@(posedge clk) disable iff (reset) hasJumps == jumpEn[0])
    else $error("hasJumps disagrees with jumpEn bit 0");

endmodule

bind predecoder predecoder_sva sva_i (
  .clk          (clk),
  .reset        (reset),
  .instr        (instr),
  .magic        (magic),
  .off          (off),
  .cls          (cls),
  .instrEn      (instrEn),
  .jInstr       (jInstr),
  .jOff         (jOff),
  .jumpEn       (jumpEn),
  .hasJumps     (hasJumps),
  .overflow     (overflow),
  .jumpOverflow (jumpOverflow)
);

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the predecoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbPredecoder --Mdir "$buildDir" -o simPredecoder -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/simPredecoder" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "TESTS FAILED" "$logFile"; then
  echo "Simulation reported a failure, see $logFile"
  exit 1
fi

if [ "$runStatus" -ne 0 ]; then
  echo "Simulator exited with status $runStatus"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== sim.f ====
+incdir+.
isaPkg.sv
bundlePkg.sv
instrClassify.sv
boundaryMask.sv
slotSelect.sv
predecoder.sv
predecoder_sva.sv
tbPredecoder.sv

// ==== slotSelect.sv ====
`include "predecoder_params.svh"
`timescale 1ns/1ps
`default_nettype none

module slotSelect #(
  parameter type payload_t = logic,
  parameter int  NUM_SLOTS = 1
) (
  input  wire [`NUM_PARCELS-1:0]            flag,
  input  wire payload_t [`NUM_PARCELS-1:0]  entry,
  output payload_t [NUM_SLOTS-1:0]          slot,
  output logic [NUM_SLOTS-1:0]              en
);

  logic [`CNT_W-1:0] rank [`NUM_PARCELS];  // Set flags below each parcel
  logic [`CNT_W-1:0] acc;
  logic [`CNT_W-1:0] total;

  always_comb begin
    acc = '0;
    for (int k = 0; k < `NUM_PARCELS; k++) begin
      rank[k] = acc;
      acc     = acc + {{(`CNT_W-1){1'b0}}, flag[k]};
    end
    total = acc;
  end

  // At most one flagged parcel has a given rank
  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slot[i] = '0;
      for (int k = 0; k < `NUM_PARCELS; k++) begin
        if (flag[k] && rank[k] == `CNT_W'(i)) begin
          slot[i] = entry[k];
        end
      end
      en[i] = total > `CNT_W'(i);  // Thermometer of the count
    end
  end

endmodule

`default_nettype wire

// ==== tbPredecoder.sv ====
`include "predecoder_params.svh"
`timescale 1ns/1ps
`default_nettype none

module tbPredecoder;

  localparam int NUM_BUNDLES    = 1500;
  localparam int TIMEOUT_CYCLES = 2000 + NUM_BUNDLES;
  localparam int SEED           = 47445;
  localparam int CHK_W          = 1024;
  localparam int END_LSB        = `NUM_PARCELS * `PARCEL_W;

  typedef struct packed {
    bundlePkg::instrWord_t [`INSTR_SLOTS-1:0] instr;
    bundlePkg::magic_t [`INSTR_SLOTS-1:0]     magic;
    bundlePkg::offset_t [`INSTR_SLOTS-1:0]    off;
    isaPkg::instrClass_t [`INSTR_SLOTS-1:0]   cls;
    logic [`INSTR_SLOTS-1:0]                  instrEn;
    bundlePkg::instrWord_t [`JUMP_SLOTS-1:0]  jInstr;
    bundlePkg::offset_t [`JUMP_SLOTS-1:0]     jOff;
    logic [`JUMP_SLOTS-1:0]                   jumpEn;
    logic                                     hasJumps;
    logic                                     overflow;
    logic                                     jumpOverflow;
  } outputs_t;

  logic                                     clk;
  logic                                     reset;
  logic [`BUNDLE_W-1:0]                     bundle;
  logic [`TAIL_W-1:0]                       btail;
  bundlePkg::offset_t                       startOff;
  bundlePkg::instrWord_t [`INSTR_SLOTS-1:0] instr;
  bundlePkg::magic_t [`INSTR_SLOTS-1:0]     magic;
  bundlePkg::offset_t [`INSTR_SLOTS-1:0]    off;
  isaPkg::instrClass_t [`INSTR_SLOTS-1:0]   cls;
  logic [`INSTR_SLOTS-1:0]                  instrEn;
  bundlePkg::instrWord_t [`JUMP_SLOTS-1:0]  jInstr;
  bundlePkg::offset_t [`JUMP_SLOTS-1:0]     jOff;
  logic [`JUMP_SLOTS-1:0]                   jumpEn;
  logic                                     hasJumps;
  logic                                     overflow;
  logic                                     jumpOverflow;

  outputs_t expQ[$];  // One entry per bundle in flight
  int       cycleCount = 0;
  int       sentCount  = 0;

  predecoder dut_i (
    .clk          (clk),
    .reset        (reset),
    .bundle       (bundle),
    .btail        (btail),
    .startOff     (startOff),
    .instr        (instr),
    .magic        (magic),
    .off          (off),
    .cls          (cls),
    .instrEn      (instrEn),
    .jInstr       (jInstr),
    .jOff         (jOff),
    .jumpEn       (jumpEn),
    .hasJumps     (hasJumps),
    .overflow     (overflow),
    .jumpOverflow (jumpOverflow)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  task automatic checkValue(input string name, input logic [CHK_W-1:0] got,
                            input logic [CHK_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Output check failed");
    end
  endtask

  task automatic compareOutputs(input outputs_t e);
    for (int i = 0; i < `INSTR_SLOTS; i++) begin
      checkValue($sformatf("instr[%0d]", i), CHK_W'(instr[i]), CHK_W'(e.instr[i]));
      checkValue($sformatf("magic[%0d]", i), CHK_W'(magic[i]), CHK_W'(e.magic[i]));
      checkValue($sformatf("off[%0d]", i), CHK_W'(off[i]), CHK_W'(e.off[i]));
      checkValue($sformatf("cls[%0d]", i), CHK_W'(cls[i]), CHK_W'(e.cls[i]));
    end
    for (int j = 0; j < `JUMP_SLOTS; j++) begin
      checkValue($sformatf("jInstr[%0d]", j), CHK_W'(jInstr[j]), CHK_W'(e.jInstr[j]));
      checkValue($sformatf("jOff[%0d]", j), CHK_W'(jOff[j]), CHK_W'(e.jOff[j]));
    end
    checkValue("instrEn", CHK_W'(instrEn), CHK_W'(e.instrEn));
    checkValue("jumpEn", CHK_W'(jumpEn), CHK_W'(e.jumpEn));
    checkValue("hasJumps", CHK_W'(hasJumps), CHK_W'(e.hasJumps));
    checkValue("overflow", CHK_W'(overflow), CHK_W'(e.overflow));
    checkValue("jumpOverflow", CHK_W'(jumpOverflow), CHK_W'(e.jumpOverflow));
  endtask

  // Class table by opcode range
  function automatic isaPkg::instrClass_t classOf(input bundlePkg::instrWord_t word,
                                                  input logic longForm);
    int                  op;
    int                  sub;
    isaPkg::instrClass_t c;
    op  = int'(word[0][7:0]);
    sub = int'(word[0][5:0]);
    c   = '0;
    if (longForm) begin
      if (op <= 39) begin
        if (word[0][2]) c[isaPkg::clsMul] = 1'b1;
        else c[isaPkg::clsAlu] = 1'b1;
      end else if (op >= 40 && op <= 45) begin
        c[isaPkg::clsShift] = 1'b1;
      end else if (op >= 64 && op <= 127) begin
        if (word[0][0]) c[isaPkg::clsStore] = 1'b1;
        else c[isaPkg::clsLoad] = 1'b1;
      end else if (op >= 160 && op <= 175) begin
        c[isaPkg::clsJump] = 1'b1;
        c[isaPkg::clsAlu]  = 1'b1;
      end else if (op == int'(isaPkg::opLongJump) || op == int'(isaPkg::opUncondJump)) begin
        c[isaPkg::clsJump] = 1'b1;
      end else if (op == int'(isaPkg::opIndirJump)) begin
        c[isaPkg::clsJump]  = 1'b1;
        c[isaPkg::clsIndir] = 1'b1;
      end else if (op == int'(isaPkg::opSys)) begin
        c[isaPkg::clsSys] = 1'b1;
      end
    end else begin
      if (sub <= 15) c[isaPkg::clsAlu] = 1'b1;
      else if (sub >= 48 && sub <= 51) c[isaPkg::clsJump] = 1'b1;
    end
    return c;
  endfunction

  function automatic outputs_t modelBundle(input logic [`BUNDLE_W-1:0] b,
                                           input logic [`TAIL_W-1:0] t,
                                           input bundlePkg::offset_t so);
    outputs_t                                       e;
    logic [`NUM_PARCELS+`MAX_LEN:0]                 endAt;  // endAt[j+1] is end[j]
    bundlePkg::parcel_t [`NUM_PARCELS+`MAX_LEN-1:0] p;
    bundlePkg::instrWord_t                          word;
    bundlePkg::magic_t                              mg;
    isaPkg::instrClass_t                            c;
    int                                             n;
    int                                             jn;
    e     = '0;
    n     = 0;
    jn    = 0;
    endAt = '0;
    p     = '0;
    endAt[0] = 1'b1;  // Implied end before parcel 0
    for (int j = 0; j < `NUM_PARCELS; j++) begin
      endAt[j+1] = b[END_LSB + j];
      p[j]       = b[j*`PARCEL_W +: `PARCEL_W];
    end
    endAt[`NUM_PARCELS+1] = t[`PARCEL_W];
    p[`NUM_PARCELS]       = t[`PARCEL_W-1:0];
    for (int k = 0; k < `NUM_PARCELS; k++) begin
      for (int m = 0; m < `MAX_LEN; m++) begin
        word[m] = p[k+m];
        mg[m]   = ~endAt[k+m+1];
      end
      c = classOf(word, mg[0]);
      if (endAt[k] && k >= int'(so)) begin
        if (n < `INSTR_SLOTS) begin
          e.instr[n] = word;
          e.magic[n] = mg;
          e.off[n]   = bundlePkg::offset_t'(k);
          e.cls[n]   = c;
        end
        n++;
        if (c[isaPkg::clsJump]) begin
          if (jn < `JUMP_SLOTS) begin
            e.jInstr[jn] = word;
            e.jOff[jn]   = bundlePkg::offset_t'(k);
          end
          jn++;
        end
      end
    end
    for (int i = 0; i < `INSTR_SLOTS; i++) e.instrEn[i] = n > i;
    for (int i = 0; i < `JUMP_SLOTS; i++) e.jumpEn[i] = jn > i;
    e.overflow     = n > `INSTR_SLOTS || int'(so) == 15;
    e.jumpOverflow = jn > `JUMP_SLOTS;
    e.hasJumps     = jn != 0;
    return e;
  endfunction

  function automatic logic [`BUNDLE_W-1:0] randomBits();
    logic [`BUNDLE_W-1:0] r;
    for (int i = 0; i < `BUNDLE_W / 32; i++) r[i*32 +: 32] = $urandom;
    return r;
  endfunction

  function automatic isaPkg::opcode_t pickJumpOpcode();
    case ($urandom % 4)
      0:       return isaPkg::opLongJump;
      1:       return isaPkg::opUncondJump;
      2:       return isaPkg::opIndirJump;
      default: return isaPkg::opcode_t'(160 + $urandom % 16);  // Conditional
    endcase
  endfunction

  // Called at a falling edge; leaves at the next one
  task automatic sendBundle(input logic [`BUNDLE_W-1:0] b, input logic [`TAIL_W-1:0] t,
                            input bundlePkg::offset_t so);
    if (expQ.size() != 0) compareOutputs(expQ.pop_front());
    bundle   = b;
    btail    = t;
    startOff = so;
    expQ.push_back(modelBundle(b, t, so));
    sentCount++;
    @(negedge clk);
  endtask

  task automatic sweepClasses();
    logic [`BUNDLE_W-1:0] b;
    int                   op;
    op = 0;
    // Two-parcel instructions start on every even parcel
    while (op < 256) begin
      b = randomBits();
      b[END_LSB +: `NUM_PARCELS] = 15'h2AAA;
      for (int k = 0; k < `NUM_PARCELS; k += 2) begin
        b[k*`PARCEL_W +: 8] = 8'(op);
        op++;
      end
      sendBundle(b, `TAIL_W'($urandom), '0);
    end
    for (int base = 0; base < 64; base += `INSTR_SLOTS) begin
      b = randomBits();
      b[END_LSB +: `NUM_PARCELS] = '1;  // All one-parcel
      for (int k = 0; k < `INSTR_SLOTS; k++) b[k*`PARCEL_W +: 6] = 6'((base + k) % 64);
      sendBundle(b, `TAIL_W'($urandom), '0);
    end
  endtask

  task automatic stepJumpCounts();
    logic [`BUNDLE_W-1:0] b;
    int                   rot;
    for (int n = 0; n <= 8; n++) begin
      repeat (8) begin
        b   = randomBits();
        rot = int'($urandom % 8);
        b[END_LSB +: `NUM_PARCELS] = 15'h2AAA;
        for (int s = 0; s < 8; s++) begin
          if ((s + rot) % 8 < n) b[2*s*`PARCEL_W +: 8] = pickJumpOpcode();
          else b[2*s*`PARCEL_W +: 8] = 8'($urandom % 32);  // ALU or MUL
        end
        sendBundle(b, `TAIL_W'($urandom), '0);
      end
    end
  endtask

  task automatic overfillSlots();
    logic [`BUNDLE_W-1:0] b;
    repeat (10) begin
      b = randomBits();
      b[END_LSB +: `NUM_PARCELS] = '1;
      sendBundle(b, `TAIL_W'($urandom), bundlePkg::offset_t'($urandom % 4));
    end
    repeat (10) sendBundle(randomBits(), `TAIL_W'($urandom), bundlePkg::offset_t'(15));
  endtask

  task automatic streamRandom(input int count);
    logic [`BUNDLE_W-1:0] b;
    bundlePkg::offset_t   so;
    repeat (count) begin
      b = randomBits();
      if ($urandom % 2 == 1) begin
        b[END_LSB +: `NUM_PARCELS] = b[END_LSB +: `NUM_PARCELS] & 15'($urandom);  // Longer ones
      end
      if ($urandom % 4 != 0) so = bundlePkg::offset_t'($urandom % 4);
      else so = bundlePkg::offset_t'($urandom % 16);
      sendBundle(b, `TAIL_W'($urandom), so);
    end
  endtask

  initial begin
    outputs_t cleared;
    void'($urandom(SEED));
    cleared   = '0;
    reset     = 1'b1;
    bundle    = '0;
    btail     = '0;
    startOff  = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    expQ.push_back(cleared);  // Still the reset values here
    reset = 1'b0;
    sweepClasses();
    stepJumpCounts();
    overfillSlots();
    streamRandom(NUM_BUNDLES - sentCount);
    compareOutputs(expQ.pop_front());
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
